//--- hw/fpAdd_macros.svh
// Single-precision format constants
`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

// Field widths of an IEEE 754 single-precision word
`define FP_EXP_WIDTH 8
`define FP_MAN_WIDTH 23

// Whole word and significand with the hidden 1
`define FP_WIDTH (1 + `FP_EXP_WIDTH + `FP_MAN_WIDTH)
`define FP_SIG_WIDTH (`FP_MAN_WIDTH + 1)

// All-ones exponent marks infinity or NaN
`define FP_EXP_MAX 8'd255

// Invalid-operation result, positive sign and full mantissa
`define FP_QNAN 32'h7FFFFFFF

`endif

//--- hw/fpAddPkg.sv
// Floating-point adder types
`include "fpAdd_macros.svh"

package fpAddPkg;

    // Kinds of value a single-precision word can hold
    typedef enum logic [1:0]
    {
        classZero   = 2'b00,   // Zero, subnormals flushed here too
        classNormal = 2'b01,
        classInf    = 2'b10,
        classNaN    = 2'b11
    } fpClass;

    // Subtraction is addition with B's sign flipped
    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp;

    // Class of a packed word
    function automatic fpClass classify(input logic [`FP_WIDTH-1:0] word);
        logic [`FP_EXP_WIDTH-1:0] exponent;
        logic [`FP_MAN_WIDTH-1:0] mantissa;
        fpClass kind;
        exponent = word[`FP_WIDTH-2:`FP_MAN_WIDTH];
        mantissa = word[`FP_MAN_WIDTH-1:0];
        if (exponent == '0)
            kind = classZero;
        else if (exponent == `FP_EXP_MAX)
            kind = (mantissa != '0) ? classNaN : classInf;
        else
            kind = classNormal;
        return kind;
    endfunction

endpackage

//--- hw/fpSpecialCase.sv
// NaN and infinity result selection
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpSpecialCase
(
    input  logic [`FP_WIDTH-1:0] a,
    input  logic [`FP_WIDTH-1:0] b,
    input  fpAddPkg::fpOp        op,
    output logic                 isSpecial,
    output logic [`FP_WIDTH-1:0] specialResult
);

    logic [`FP_WIDTH-1:0] bEffective;   // B with the operation folded into its sign
    fpAddPkg::fpClass     classA;
    fpAddPkg::fpClass     classB;
    logic                 aIsInf;
    logic                 bIsInf;
    logic                 anyNaN;

    always_comb
    begin
        bEffective = {b[`FP_WIDTH-1] ^ (op == fpAddPkg::opSub), b[`FP_WIDTH-2:0]};

        classA = fpAddPkg::classify(a);
        classB = fpAddPkg::classify(bEffective);

        aIsInf = (classA == fpAddPkg::classInf);
        bIsInf = (classB == fpAddPkg::classInf);
        anyNaN = (classA == fpAddPkg::classNaN) || (classB == fpAddPkg::classNaN);

        // Arithmetic path result is only overridden by Inf or NaN
        isSpecial = anyNaN || aIsInf || bIsInf;

        // A's NaN has priority
        if (classA == fpAddPkg::classNaN)
            specialResult = a;
        else if (classB == fpAddPkg::classNaN)
            specialResult = b;                      // B's NaN passes unchanged
        else if (aIsInf && bIsInf)
        begin
            // Opposite infinities have no defined sum
            if (a[`FP_WIDTH-1] == bEffective[`FP_WIDTH-1])
                specialResult = a;
            else
                specialResult = `FP_QNAN;
        end
        else if (aIsInf)
            specialResult = a;
        else if (bIsInf)
            specialResult = bEffective;             // Sign follows the operation
        else
            specialResult = '0;                     // Unused, arithmetic path wins
    end

endmodule

//--- hw/fpAlignAdd.sv
// Operand alignment and mantissa add stage
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpAlignAdd
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  logic [`FP_WIDTH-1:0]     a,
    input  logic [`FP_WIDTH-1:0]     b,
    input  fpAddPkg::fpOp            op,
    output logic                     alignedSign,
    output logic [`FP_EXP_WIDTH-1:0] exponentOut,
    output logic [`FP_SIG_WIDTH-1:0] alignedResult,
    output logic                     carryOut,
    output logic                     guardBit,
    output logic                     roundBit,
    output logic                     stickyBit
);

    // Significand plus room for every bit a capped shift can push out
    localparam int extWidth = 2 * `FP_SIG_WIDTH + 2;
    localparam logic [`FP_EXP_WIDTH-1:0] maxShift = `FP_SIG_WIDTH + 2;

    logic                     signA, signB;
    logic [`FP_EXP_WIDTH-1:0] expA, expB;
    logic [`FP_SIG_WIDTH-1:0] sigA, sigB;
    logic                     swap;
    logic                     signLarge, signSmall;
    logic [`FP_EXP_WIDTH-1:0] expLarge, expSmall;
    logic [`FP_SIG_WIDTH-1:0] sigLarge, sigSmall;
    logic [`FP_EXP_WIDTH-1:0] shiftAmount;
    logic [extWidth-1:0]      shiftedSmall;
    logic [`FP_SIG_WIDTH-1:0] alignedSmall;
    logic                     guardNext, roundNext, stickyNext;
    logic [`FP_SIG_WIDTH:0]   sumWide;
    logic [`FP_SIG_WIDTH+2:0] diffWide;          // Difference with G, R, S below it
    logic                     effectiveSub;

    always_comb
    begin
        signA = a[`FP_WIDTH-1];
        signB = b[`FP_WIDTH-1] ^ (op == fpAddPkg::opSub);
        expA = a[`FP_WIDTH-2:`FP_MAN_WIDTH];
        expB = b[`FP_WIDTH-2:`FP_MAN_WIDTH];

        // Flush subnormals, restore the hidden 1 otherwise
        sigA = (expA == '0) ? '0 : {1'b1, a[`FP_MAN_WIDTH-1:0]};
        sigB = (expB == '0) ? '0 : {1'b1, b[`FP_MAN_WIDTH-1:0]};

        // Larger magnitude goes first
        swap = {expB, sigB} > {expA, sigA};
        if (swap)
        begin
            {signLarge, expLarge, sigLarge} = {signB, expB, sigB};
            {signSmall, expSmall, sigSmall} = {signA, expA, sigA};
        end
        else
        begin
            {signLarge, expLarge, sigLarge} = {signA, expA, sigA};
            {signSmall, expSmall, sigSmall} = {signB, expB, sigB};
        end

        // Beyond maxShift everything already lands in sticky
        shiftAmount = ((expLarge - expSmall) > maxShift) ? maxShift : (expLarge - expSmall);
        shiftedSmall = {sigSmall, {(extWidth - `FP_SIG_WIDTH){1'b0}}} >> shiftAmount;

        alignedSmall = shiftedSmall[extWidth-1 -: `FP_SIG_WIDTH];
        guardNext = shiftedSmall[`FP_SIG_WIDTH+1];
        roundNext = shiftedSmall[`FP_SIG_WIDTH];
        stickyNext = |shiftedSmall[`FP_SIG_WIDTH-1:0];

        effectiveSub = signLarge ^ signSmall;
        sumWide = {1'b0, sigLarge} + {1'b0, alignedSmall};
        diffWide = {sigLarge, 3'b000} - {alignedSmall, guardNext, roundNext, stickyNext};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alignedSign <= 1'b0;
            exponentOut <= '0;
            alignedResult <= '0;
            carryOut <= 1'b0;
            guardBit <= 1'b0;
            roundBit <= 1'b0;
            stickyBit <= 1'b0;
        end
        else if (valid)
        begin
            alignedSign <= signLarge;           // Larger operand sets the sign
            exponentOut <= expLarge;
            if (effectiveSub)
            begin
                alignedResult <= diffWide[`FP_SIG_WIDTH+2:3];
                carryOut <= 1'b0;               // Never carries, large minus small
                {guardBit, roundBit, stickyBit} <= diffWide[2:0];
            end
            else
            begin
                alignedResult <= sumWide[`FP_SIG_WIDTH-1:0];
                carryOut <= sumWide[`FP_SIG_WIDTH];
                {guardBit, roundBit, stickyBit} <= {guardNext, roundNext, stickyNext};
            end
        end
    end

endmodule

//--- hw/fpNormalize.sv
// Result normalization and rounding
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpNormalize
(
    input  logic                     alignedSign,
    input  logic [`FP_EXP_WIDTH-1:0] exponentOut,
    input  logic [`FP_SIG_WIDTH-1:0] alignedResult,
    input  logic                     carryOut,
    input  logic                     guardBit,
    input  logic                     roundBit,
    input  logic                     stickyBit,
    input  logic                     isSpecial,
    input  logic [`FP_WIDTH-1:0]     specialResult,
    output logic [`FP_WIDTH-1:0]     normalizedWord,
    output fpAddPkg::fpClass         normalizedClass
);

    logic [4:0]                 leadingZeros;
    logic [`FP_SIG_WIDTH+2:0]   extended;       // Sum followed by G, R, S
    logic [`FP_SIG_WIDTH+2:0]   shifted;
    logic [`FP_SIG_WIDTH-1:0]   preMantissa;
    logic [`FP_EXP_WIDTH+1:0]   preExponent;    // Two spare bits for overflow
    logic                       preGuard, preSticky;
    logic                       zeroSum, underflow, roundUp;
    logic [`FP_SIG_WIDTH:0]     rounded;
    logic [`FP_MAN_WIDTH-1:0]   finalMantissa;
    logic [`FP_EXP_WIDTH+1:0]   finalExponent;
    logic [`FP_WIDTH-1:0]       arithWord;

    // Highest set bit wins, all zeros gives 24
    function automatic logic [4:0] countLeadingZeros(input logic [`FP_SIG_WIDTH-1:0] value);
        logic [4:0] count;
        count = 5'(`FP_SIG_WIDTH);
        for (int i = 0; i < `FP_SIG_WIDTH; i++)
            if (value[i])
                count = 5'(`FP_SIG_WIDTH - 1 - i);
        return count;
    endfunction

    always_comb
    begin
        leadingZeros = countLeadingZeros(alignedResult);
        extended = {alignedResult, guardBit, roundBit, stickyBit};
        shifted = extended << leadingZeros;

        zeroSum = !carryOut && (extended == '0);
        underflow = !carryOut && ({2'b00, exponentOut} <= {5'b00000, leadingZeros});

        if (carryOut)
        begin
            // Shift right once, dropped bit becomes guard
            preMantissa = {1'b1, alignedResult[`FP_SIG_WIDTH-1:1]};
            preGuard = alignedResult[0];
            preSticky = guardBit | roundBit | stickyBit;
            preExponent = {2'b00, exponentOut} + 10'd1;
        end
        else
        begin
            preMantissa = shifted[`FP_SIG_WIDTH+2:3];
            preGuard = shifted[2];
            preSticky = |shifted[1:0];
            preExponent = {2'b00, exponentOut} - {5'b00000, leadingZeros};
        end

        // Round to nearest, ties to even
        roundUp = preGuard & (preSticky | preMantissa[0]);
        rounded = {1'b0, preMantissa} + {{`FP_SIG_WIDTH{1'b0}}, roundUp};
        if (rounded[`FP_SIG_WIDTH])
        begin
            finalMantissa = rounded[`FP_SIG_WIDTH-1:1];   // All-ones rolled over to 1.0
            finalExponent = preExponent + 10'd1;
        end
        else
        begin
            finalMantissa = rounded[`FP_MAN_WIDTH-1:0];
            finalExponent = preExponent;
        end

        if (zeroSum)
            arithWord = '0;                                 // Exact cancellation is +0
        else if (underflow)
            arithWord = {alignedSign, {(`FP_WIDTH-1){1'b0}}};
        else if (finalExponent >= {2'b00, `FP_EXP_MAX})
            arithWord = {alignedSign, `FP_EXP_MAX, {`FP_MAN_WIDTH{1'b0}}};
        else
            arithWord = {alignedSign, finalExponent[`FP_EXP_WIDTH-1:0], finalMantissa};

        normalizedWord = isSpecial ? specialResult : arithWord;
        normalizedClass = fpAddPkg::classify(normalizedWord);
    end

endmodule

//--- hw/fpAdder.sv
// Pipelined single-precision adder
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpAdder
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  fpAddPkg::fpOp        op,
    input  logic [`FP_WIDTH-1:0] a,
    input  logic [`FP_WIDTH-1:0] b,
    output logic                 done,
    output logic [`FP_WIDTH-1:0] result,
    output fpAddPkg::fpClass     resultClass
);

    fpAddPkg::fpOp            opReg;
    logic [`FP_WIDTH-1:0]     aReg, bReg;
    logic                     validStage1, validStage2;

    logic                     isSpecial, isSpecialReg;
    logic [`FP_WIDTH-1:0]     specialResult, specialResultReg;

    logic                     alignedSign;
    logic [`FP_EXP_WIDTH-1:0] exponentOut;
    logic [`FP_SIG_WIDTH-1:0] alignedResult;
    logic                     carryOut, guardBit, roundBit, stickyBit;

    logic [`FP_WIDTH-1:0]     normalizedWord;
    fpAddPkg::fpClass         normalizedClass;

    // Valid bit follows each operand pair
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            validStage1 <= 1'b0;
            validStage2 <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            validStage1 <= start;
            validStage2 <= validStage1;
            done <= validStage2;                    // One-cycle pulse per item
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            opReg <= op;
            aReg <= a;
            bReg <= b;
        end
        if (validStage1)
        begin
            isSpecialReg <= isSpecial;              // Kept in step with fpAlignAdd outputs
            specialResultReg <= specialResult;
        end
    end

    fpSpecialCase specialCase_i (.a(aReg), .b(bReg), .op(opReg), .isSpecial(isSpecial),
        .specialResult(specialResult));

    fpAlignAdd alignAdd_i (.clk(clk), .reset(reset), .valid(validStage1), .a(aReg), .b(bReg),
        .op(opReg), .alignedSign(alignedSign), .exponentOut(exponentOut),
        .alignedResult(alignedResult), .carryOut(carryOut), .guardBit(guardBit),
        .roundBit(roundBit), .stickyBit(stickyBit));

    fpNormalize normalize_i (.alignedSign(alignedSign), .exponentOut(exponentOut),
        .alignedResult(alignedResult), .carryOut(carryOut), .guardBit(guardBit),
        .roundBit(roundBit), .stickyBit(stickyBit), .isSpecial(isSpecialReg),
        .specialResult(specialResultReg), .normalizedWord(normalizedWord),
        .normalizedClass(normalizedClass));

    // Output registers, zero until the first result
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result <= '0;
            resultClass <= fpAddPkg::classZero;
        end
        else if (validStage2)
        begin
            result <= normalizedWord;
            resultClass <= normalizedClass;
        end
    end

endmodule

//--- bench/fpAdderClock.sv
// Testbench clock source
`timescale 1ns/1ps

module fpAdderClock
(
    output logic clk
);

    localparam int halfPeriod = 50;     // 100 ns period

    initial
    begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

endmodule

//--- bench/fpAdder_sva.sv
// Adder pipeline assertions
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpAdderSva
(
    input logic                 clk,
    input logic                 reset,
    input logic                 start,
    input logic                 done,
    input logic [`FP_WIDTH-1:0] result,
    input fpAddPkg::fpClass     resultClass
);

    // Done rises two edges after start and is sampled one edge later
    localparam int doneDelay = 3;

    int   failureCount = 0;     // Failed assertions so far
    logic nanExponent;
    logic nanMantissa;

    assign nanExponent = (result[`FP_WIDTH-2:`FP_MAN_WIDTH] == `FP_EXP_MAX);
    assign nanMantissa = (result[`FP_MAN_WIDTH-1:0] != '0);

    // Reset clears done
    assert property (@(posedge clk) reset |=> !done)
    else
    begin
        $error("done high while reset is applied");
        failureCount++;
    end

    // First cycle out of reset stays quiet
    assert property (@(posedge clk) $fell(reset) |=> !done)
    else
    begin
        $error("done high in the cycle after reset");
        failureCount++;
    end

    assert property (@(posedge clk) disable iff (reset) start |-> ##doneDelay done)
    else
    begin
        $error("start not followed by done two cycles later");
        failureCount++;
    end

    assert property (@(posedge clk) disable iff (reset) done |-> $past(start, doneDelay))
    else
    begin
        $error("done without a matching start");
        failureCount++;
    end

    // NaN encoding must report the NaN class
    assert property (@(posedge clk) disable iff (reset)
        (nanExponent && nanMantissa) |-> (resultClass == fpAddPkg::classNaN))
    else
    begin
        $error("NaN result with wrong class");
        failureCount++;
    end

endmodule

bind fpAdder fpAdderSva sva_i
(
    .clk(clk),
    .reset(reset),
    .start(start),
    .done(done),
    .result(result),
    .resultClass(resultClass)
);

//--- bench/fpAdderTb.sv
// Floating-point adder testbench
`timescale 1ns/1ps
`include "fpAdd_macros.svh"

module fpAdderTb;

    localparam int clockPeriod = 100;
    localparam int resetCycles = 5;
    localparam int idleCycles = 3;
    localparam int doneEdges = 3;       // Falling edges from drive to visible done
    localparam string vectorFile = "bench/fpAdder_input.txt";

    logic                 clk;
    logic                 reset;
    logic                 start;
    fpAddPkg::fpOp        op;
    logic [`FP_WIDTH-1:0] a;
    logic [`FP_WIDTH-1:0] b;
    logic                 done;
    logic [`FP_WIDTH-1:0] result;
    fpAddPkg::fpClass     resultClass;

    // Vectors as read from the file
    fpAddPkg::fpOp        opList[$];
    logic [`FP_WIDTH-1:0] aList[$];
    logic [`FP_WIDTH-1:0] bList[$];
    logic [`FP_WIDTH-1:0] expResult[$];
    fpAddPkg::fpClass     expClass[$];

    int pendingId[$];                   // Items in flight with the oldest first
    int pendingDue[$];

    int  vectorCount = 0;
    int  edgeCount = 0;
    int  passCount = 0;
    int  failCount = 0;
    int  errorCount = 0;
    bit  loadDone = 1'b0;

    fpAdderClock clock_i (.clk(clk));

    fpAdder dut_i (.clk(clk), .reset(reset), .start(start), .op(op), .a(a), .b(b),
        .done(done), .result(result), .resultClass(resultClass));

    task automatic checkResult(input string label, input logic [`FP_WIDTH-1:0] actual,
        input logic [`FP_WIDTH-1:0] expected, inout bit ok);
        if (actual !== expected)
        begin
            $display("MISMATCH %t: %s result %h, expected %h", $time, label, actual, expected);
            ok = 1'b0;
        end
    endtask

    task automatic checkClass(input string label, input fpAddPkg::fpClass actual,
        input fpAddPkg::fpClass expected, inout bit ok);
        if (actual !== expected)
        begin
            $display("MISMATCH %t: %s class %s, expected %s", $time, label, actual.name(),
                expected.name());
            ok = 1'b0;
        end
    endtask

    task automatic loadVectors();
        int    fd;
        int    fields;
        string line;
        logic [31:0] opValue, aValue, bValue, resValue, classValue;
        fd = $fopen(vectorFile, "r");
        if (fd == 0)
        begin
            $display("Error: cannot open the vector file %s", vectorFile);
            errorCount++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h %h", opValue, aValue, bValue, resValue,
                    classValue);
                if (fields == 5)
                begin
                    opList.push_back(fpAddPkg::fpOp'(opValue[0]));
                    aList.push_back(aValue);
                    bList.push_back(bValue);
                    expResult.push_back(resValue);
                    expClass.push_back(fpAddPkg::fpClass'(classValue[1:0]));
                end
                else if (fields > 0)
                begin
                    $display("Error: malformed vector line: %s", line);
                    errorCount++;
                end
            end
            $fclose(fd);
            vectorCount = opList.size();
        end
    endtask

    task automatic nextFallingEdge();
        @(negedge clk);
        edgeCount++;
    endtask

    // Output must stay cleared until the first item completes
    task automatic checkIdle();
        bit ok;
        ok = 1'b1;
        if (done !== 1'b0)
        begin
            $display("Error at %t: done is not low before the first start", $time);
            ok = 1'b0;
        end
        checkResult("idle output", result, '0, ok);
        checkClass("idle output", resultClass, fpAddPkg::classZero, ok);
        if (!ok)
            errorCount++;
    endtask

    task automatic collectOutput();
        bit    ok;
        int    id;
        int    due;
        string label;
        if (done === 1'b1)
        begin
            if (pendingId.size() == 0)
            begin
                $display("Error at %t: done pulsed with no operation in flight", $time);
                errorCount++;
            end
            else
            begin
                id = pendingId.pop_front();
                due = pendingDue.pop_front();
                label = $sformatf("vector %0d", id);
                ok = 1'b1;
                if (edgeCount != due)
                begin
                    $display("Error at %t: %s finished at the wrong cycle", $time, label);
                    ok = 1'b0;
                end
                checkResult(label, result, expResult[id], ok);
                checkClass(label, resultClass, expClass[id], ok);
                $display("%s %s", label, ok ? "PASS" : "FAIL");
                if (ok)
                    passCount++;
                else
                    failCount++;
            end
        end
        else if (done !== 1'b0)
        begin
            $display("Error at %t: done is unknown", $time);
            errorCount++;
        end
        else if (pendingId.size() > 0 && pendingDue[0] <= edgeCount)
        begin
            id = pendingId.pop_front();
            due = pendingDue.pop_front();
            $display("Error at %t: vector %0d never signalled done", $time, id);
            $display("vector %0d FAIL", id);
            failCount++;
        end
    endtask

    task automatic runVectors();
        for (int i = 0; i < idleCycles; i++)
        begin
            nextFallingEdge();
            checkIdle();
        end
        // One start every cycle without gaps
        for (int i = 0; i < vectorCount; i++)
        begin
            nextFallingEdge();
            collectOutput();
            start = 1'b1;
            op = opList[i];
            a = aList[i];
            b = bList[i];
            pendingId.push_back(i);
            pendingDue.push_back(edgeCount + doneEdges);
        end
        while (pendingId.size() > 0)
        begin
            nextFallingEdge();
            collectOutput();
            start = 1'b0;
        end
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        reset = 1'b1;
        start = 1'b0;
        op = fpAddPkg::opAdd;
        a = '0;
        b = '0;
        loadVectors();
        loadDone = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (vectorCount > 0)
            runVectors();
        $display("Summary: %0d vectors, %0d passed, %0d failed, %0d other errors, %0d %s",
            vectorCount, passCount, failCount, errorCount, dut_i.sva_i.failureCount,
            "assertion failures");
        if (vectorCount > 0 && passCount == vectorCount && failCount == 0 && errorCount == 0
            && dut_i.sva_i.failureCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog sized from the vector count
    initial
    begin
        wait (loadDone);
        #((vectorCount + 20) * clockPeriod);
        $display("Timeout: the pipeline stalled and the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- bench/fpAdder_input.txt
# op (0 add, 1 sub), a, b, expected result, expected class (0 zero, 1 normal, 2 inf, 3 NaN)
# All fields hex, one vector per line, issued back to back
0 3F800000 40000000 40400000 1
0 3FC00000 3FC00000 40400000 1
1 40800000 3F800000 40400000 1
0 3F800000 C0000000 BF800000 1
1 3F800000 3F000000 3F000000 1
0 3DCCCCCD 3E4CCCCD 3E99999A 1
0 00000001 3F800000 3F800000 1
1 3F800001 3F800000 34000000 1
1 3FC00000 3FA00000 3E800000 1
1 3F800000 33800000 3F7FFFFF 1
1 3F800000 3F800000 00000000 0
0 40400000 C0400000 00000000 0
1 C0000000 C0000000 00000000 0
1 00800001 00800000 00000000 0
1 80800001 80800000 80000000 0
0 3F800000 33800000 3F800000 1
0 3F800001 33800000 3F800002 1
1 3F800000 33000000 3F800000 1
0 3FFFFFFF 33800000 40000000 1
0 7F7FFFFF 7F7FFFFF 7F800000 2
0 7F7FFFFF 73000000 7F800000 2
0 7FC00000 3F800000 7FC00000 3
0 3F800000 7FC00001 7FC00001 3
0 7FC00002 FFC00003 7FC00002 3
1 3F800000 FFC00005 FFC00005 3
0 7F800000 3F800000 7F800000 2
1 3F800000 7F800000 FF800000 2
0 FF800000 FF800000 FF800000 2
1 7F800000 FF800000 7F800000 2
0 7F800000 FF800000 7FFFFFFF 3
1 7F800000 7F800000 7FFFFFFF 3

//--- project.f
+incdir+hw
hw/fpAddPkg.sv
hw/fpSpecialCase.sv
hw/fpAlignAdd.sv
hw/fpNormalize.sv
hw/fpAdder.sv
bench/fpAdderClock.sv
bench/fpAdder_sva.sv
bench/fpAdderTb.sv

//--- Bender.yml
package:
  name: fp_adder

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fpAddPkg.sv
      - hw/fpSpecialCase.sv
      - hw/fpAlignAdd.sv
      - hw/fpNormalize.sv
      - hw/fpAdder.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/fpAdderClock.sv
      - bench/fpAdder_sva.sv
      - bench/fpAdderTb.sv
